// File: hdl/beam_counter.sv
// beam raster position counter with a frame start pulse, used to pace the copper program
`timescale 1ns/1ns

module beam_counter
    import video_timing_pkg::*;
#(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic              clk,
    input  logic              rst_i,
    output logic [BEAM_W-1:0] h_pos_o,
    output logic [BEAM_W-1:0] v_pos_o,
    output logic              frame_start_o
);

    // last position of each axis before it wraps
    localparam logic [BEAM_W-1:0] H_LAST = BEAM_W'(H_TOTAL - 1);
    localparam logic [BEAM_W-1:0] V_LAST = BEAM_W'(V_TOTAL - 1);

    // h steps every clock
    // v steps when h wraps, wraps itself at the bottom of the frame
    always_ff @(posedge clk) begin
        if (rst_i) begin
            h_pos_o <= '0;
            v_pos_o <= '0;
        end else if (h_pos_o == H_LAST) begin
            h_pos_o <= '0;
            if (v_pos_o == V_LAST) begin
                v_pos_o <= '0;
            end else begin
                v_pos_o <= v_pos_o + 1'b1;
            end
        end else begin
            h_pos_o <= h_pos_o + 1'b1;
        end
    end

    // top-left corner of the raster
    // high for exactly one clock per frame once running,
    // and on the first clock out of reset
    assign frame_start_o = (h_pos_o == '0) && (v_pos_o == '0);

    // positions never leave the raster
    a_h_in_range: assert property (
        @(posedge clk) disable iff (rst_i) h_pos_o < H_TOTAL
    ) else $error("beam_counter: h_pos beyond H_TOTAL");

    a_v_in_range: assert property (
        @(posedge clk) disable iff (rst_i) v_pos_o < V_TOTAL
    ) else $error("beam_counter: v_pos beyond V_TOTAL");

endmodule

// File: hdl/copper_fsm.sv
// copper instruction sequencer, fetches from program RAM, waits on the beam and issues register writes
`timescale 1ns/1ns

module copper_fsm
    import copper_pkg::*, video_timing_pkg::*;
#(
    parameter int AWIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst_i,
    // level, low parks the engine in idle
    input  logic                  copper_en_i,
    input  logic                  frame_start_i,
    input  logic [BEAM_W-1:0]     h_pos_i,
    input  logic [BEAM_W-1:0]     v_pos_i,
    // program RAM fetch port
    output logic [AWIDTH-1:0]     mem_addr_o,
    input  logic [WORD_W-1:0]     mem_data_i,
    // video register write, addr and data valid with the strobe
    output logic                  reg_wr_o,
    output logic [REG_ADDR_W-1:0] reg_addr_o,
    output logic [WORD_W-1:0]     reg_data_o
);

    // control state
    copper_state_t         state_q;
    logic [AWIDTH-1:0]     pc_q;
    logic                  reg_wr_q;

    // current instruction and pending write payload
    copper_op_t            op_q;
    logic [ARG_W-1:0]      arg_q;
    logic [REG_ADDR_W-1:0] reg_addr_q;
    logic [WORD_W-1:0]     reg_data_q;

    // fields of the word coming back from RAM
    copper_op_t            dec_op;
    logic [ARG_W-1:0]      dec_arg;
    logic                  wait_done;

    assign dec_op  = copper_op_t'(mem_data_i[WORD_W-1 -: OP_W]);
    assign dec_arg = mem_data_i[ARG_W-1:0];

    // beam compare for the wait in progress
    // positions are zero extended to the argument width
    always_comb begin
        case (op_q)
            OP_WAITV: wait_done = (ARG_W'(v_pos_i) >= arg_q);
            OP_WAITH: wait_done = (ARG_W'(h_pos_i) >= arg_q);
            default:  wait_done = 1'b1;
        endcase
    end

    // sequencer
    // frame start restarts the program from word 0 whatever is running
    always_ff @(posedge clk) begin
        // strobe is a single clock unless set again below
        reg_wr_q <= 1'b0;
        if (rst_i) begin
            state_q <= ST_IDLE;
            pc_q    <= '0;
        end else if (!copper_en_i) begin
            state_q <= ST_IDLE;
        end else if (frame_start_i) begin
            state_q <= ST_FETCH;
            pc_q    <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // wait here for the next frame start
                    state_q <= ST_IDLE;
                end
                ST_FETCH: begin
                    // RAM sees pc this cycle, word is back in decode
                    pc_q    <= pc_q + 1'b1;
                    state_q <= ST_DECODE;
                end
                ST_DECODE: begin
                    case (dec_op)
                        OP_MOVE: begin
                            // pc already points at the data word
                            pc_q    <= pc_q + 1'b1;
                            state_q <= ST_MOVE_DATA;
                        end
                        OP_WAITV, OP_WAITH: state_q <= ST_WAIT;
                        OP_JUMP: begin
                            pc_q    <= dec_arg[AWIDTH-1:0];
                            state_q <= ST_FETCH;
                        end
                        // END and unknown opcodes stop until next frame
                        default: state_q <= ST_HALT;
                    endcase
                end
                ST_WAIT: begin
                    if (wait_done) begin
                        state_q <= ST_FETCH;
                    end
                end
                ST_MOVE_DATA: begin
                    // data word is on mem_data_i now
                    reg_wr_q <= 1'b1;
                    state_q  <= ST_MOVE_WRITE;
                end
                ST_MOVE_WRITE: state_q <= ST_FETCH;
                ST_HALT:       state_q <= ST_HALT;
                default:       state_q <= ST_IDLE;
            endcase
        end
    end

    // latch opcode and argument while decoding
    always_ff @(posedge clk) begin
        if (state_q == ST_DECODE) begin
            op_q  <= dec_op;
            arg_q <= dec_arg;
        end
    end

    // capture register number and data of a MOVE
    always_ff @(posedge clk) begin
        if (state_q == ST_MOVE_DATA) begin
            reg_addr_q <= arg_q[REG_ADDR_W-1:0];
            reg_data_q <= mem_data_i;
        end
    end

    assign mem_addr_o = pc_q;
    assign reg_wr_o   = reg_wr_q;
    assign reg_addr_o = reg_addr_q;
    assign reg_data_o = reg_data_q;

    // strobe only ever lines up with the write state
    a_wr_in_move: assert property (
        @(posedge clk) disable iff (rst_i) reg_wr_o |-> (state_q == ST_MOVE_WRITE)
    ) else $error("copper_fsm: reg_wr_o outside ST_MOVE_WRITE");

    // every MOVE writes once, never back to back
    a_wr_single: assert property (
        @(posedge clk) disable iff (rst_i) reg_wr_o |=> !reg_wr_o
    ) else $error("copper_fsm: reg_wr_o high two cycles in a row");

endmodule

// File: hdl/copper_mem.sv
// copper program block RAM, host writes on one side and FSM fetches on the other, all on clk
`timescale 1ns/1ns

module copper_mem
    import copper_pkg::*;
#(
    parameter int AWIDTH = 10
) (
    input  logic              clk,
    // host write side
    input  logic              wr_en_i,
    input  logic [AWIDTH-1:0] wr_addr_i,
    input  logic [WORD_W-1:0] wr_data_i,
    // fetch side, one cycle latency
    input  logic [AWIDTH-1:0] rd_addr_i,
    output logic [WORD_W-1:0] rd_data_o
);

    localparam int DEPTH = 2 ** AWIDTH;

    // program storage, inferred as block RAM
    logic [WORD_W-1:0] bram [0:DEPTH-1];

    // preload every word with the wait-forever instruction
    // a copper enabled before any load then makes no writes
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            bram[i] = FILL_WORD;
        end
    end

    // host write port
    always @(posedge clk) begin
        if (wr_en_i) begin
            bram[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read
    // same-cycle write to the read address returns the new word,
    // which is what the RAM primitive does in hardware
    always_ff @(posedge clk) begin
        if (wr_en_i && (rd_addr_i == wr_addr_i)) begin
            rd_data_o <= wr_data_i;
        end else begin
            rd_data_o <= bram[rd_addr_i];
        end
    end

    // a write with an undefined address would corrupt an unknown word
    a_wr_addr_known: assert property (
        @(posedge clk) wr_en_i |-> !$isunknown(wr_addr_i)
    ) else $error("copper_mem: write with unknown address");

endmodule

// File: hdl/copper_pkg.sv
// copper instruction set, FSM states and field widths, imported by the copper engine and its testbench
package copper_pkg;

    // instruction and data word width
    localparam int WORD_W     = 16;
    // opcode sits in the upper field, argument below it
    localparam int OP_W       = 4;
    localparam int ARG_W      = 12;
    // register number of a MOVE, taken from the low argument bits
    localparam int REG_ADDR_W = 8;

    // opcodes, anything not listed behaves like OP_END
    typedef enum logic [OP_W-1:0] {
        OP_END   = 4'd0,
        OP_MOVE  = 4'd1,
        OP_WAITV = 4'd2,
        OP_WAITH = 4'd3,
        OP_JUMP  = 4'd4
    } copper_op_t;

    // sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_WAIT,
        ST_MOVE_DATA,
        ST_MOVE_WRITE,
        ST_HALT
    } copper_state_t;

    // power-up fill of program memory
    // WAITV for line 4095, which the beam never reaches,
    // so an unloaded program just sits there
    localparam logic [WORD_W-1:0] FILL_WORD = {OP_WAITV, {ARG_W{1'b1}}};

endpackage

// File: hdl/copper_top.sv
// copper co-processor top, ties program RAM, beam counter and sequencer together for the video chip
`timescale 1ns/1ns

module copper_top
    import copper_pkg::*, video_timing_pkg::*;
#(
    parameter int AWIDTH  = 10,
    parameter int H_TOTAL = DEF_H_TOTAL,
    parameter int V_TOTAL = DEF_V_TOTAL
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  copper_en_i,
    // host program load port
    input  logic                  prog_wr_i,
    input  logic [AWIDTH-1:0]     prog_addr_i,
    input  logic [WORD_W-1:0]     prog_data_i,
    // register writes towards the video registers
    output logic                  reg_wr_o,
    output logic [REG_ADDR_W-1:0] reg_addr_o,
    output logic [WORD_W-1:0]     reg_data_o,
    // beam position for the rest of the chip
    output logic [BEAM_W-1:0]     h_pos_o,
    output logic [BEAM_W-1:0]     v_pos_o,
    output logic                  frame_start_o
);

    // fetch path between sequencer and RAM
    logic [AWIDTH-1:0] mem_addr;
    logic [WORD_W-1:0] mem_data;

    // program RAM, host writes straight in
    copper_mem #(
        .AWIDTH (AWIDTH)
    ) i_mem (
        .clk       (clk),
        .wr_en_i   (prog_wr_i),
        .wr_addr_i (prog_addr_i),
        .wr_data_i (prog_data_i),
        .rd_addr_i (mem_addr),
        .rd_data_o (mem_data)
    );

    // raster position, shared by the sequencer and the outside
    beam_counter #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) i_beam (
        .clk           (clk),
        .rst_i         (rst_i),
        .h_pos_o       (h_pos_o),
        .v_pos_o       (v_pos_o),
        .frame_start_o (frame_start_o)
    );

    // instruction sequencer
    copper_fsm #(
        .AWIDTH (AWIDTH)
    ) i_fsm (
        .clk           (clk),
        .rst_i         (rst_i),
        .copper_en_i   (copper_en_i),
        .frame_start_i (frame_start_o),
        .h_pos_i       (h_pos_o),
        .v_pos_i       (v_pos_o),
        .mem_addr_o    (mem_addr),
        .mem_data_i    (mem_data),
        .reg_wr_o      (reg_wr_o),
        .reg_addr_o    (reg_addr_o),
        .reg_data_o    (reg_data_o)
    );

endmodule

// File: hdl/video_timing_pkg.sv
// beam raster widths and default totals, imported by the beam counter, the copper FSM and the top
package video_timing_pkg;

    // width of h and v beam positions
    // 11 bits covers totals up to 2047
    localparam int BEAM_W = 11;

    // default raster totals, 640x480 style
    // visible area plus blanking, in clocks and lines
    localparam int DEF_H_TOTAL = 800;
    localparam int DEF_V_TOTAL = 525;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the copper testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module copper_tb -f src.f -o copper_sim || exit 1

out=$(./obj_dir/copper_sim)
echo "$out"

echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1

// File: sim/copper_tb.sv
// directed testbench for the copper co-processor, compiled through src.f with copper_tb as top
`timescale 1ns/1ns

module copper_tb
    import copper_pkg::*, video_timing_pkg::*;
();

    // short raster so a frame is 480 clocks
    localparam int AWIDTH       = 10;
    localparam int H_TOTAL      = 40;
    localparam int V_TOTAL      = 12;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int WAIT_LIMIT   = FRAME_CYCLES + 40;
    localparam logic [31:0] SEED = 32'h7e3e_1a7a;

    logic                  clk;
    logic                  rst_i;
    logic                  copper_en_i;
    logic                  prog_wr_i;
    logic [AWIDTH-1:0]     prog_addr_i;
    logic [WORD_W-1:0]     prog_data_i;
    logic                  reg_wr_o;
    logic [REG_ADDR_W-1:0] reg_addr_o;
    logic [WORD_W-1:0]     reg_data_o;
    logic [BEAM_W-1:0]     h_pos_o;
    logic [BEAM_W-1:0]     v_pos_o;
    logic                  frame_start_o;

    // program image and the writes it should produce
    logic [WORD_W-1:0]     prog_words[$];
    logic [REG_ADDR_W-1:0] exp_addr[$];
    logic [WORD_W-1:0]     exp_data[$];

    // writes seen on the register port
    logic [REG_ADDR_W-1:0] wr_addr_q[$];
    logic [WORD_W-1:0]     wr_data_q[$];
    logic [BEAM_W-1:0]     wr_h_q[$];
    logic [BEAM_W-1:0]     wr_v_q[$];

    int checks;
    int errors;

    copper_top #(
        .AWIDTH  (AWIDTH),
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) i_dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .copper_en_i   (copper_en_i),
        .prog_wr_i     (prog_wr_i),
        .prog_addr_i   (prog_addr_i),
        .prog_data_i   (prog_data_i),
        .reg_wr_o      (reg_wr_o),
        .reg_addr_o    (reg_addr_o),
        .reg_data_o    (reg_data_o),
        .h_pos_o       (h_pos_o),
        .v_pos_o       (v_pos_o),
        .frame_start_o (frame_start_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // outputs are settled mid-cycle, so log each strobe at the falling edge
    always @(negedge clk) begin
        if (reg_wr_o === 1'b1) begin
            wr_addr_q.push_back(reg_addr_o);
            wr_data_q.push_back(reg_data_o);
            wr_h_q.push_back(h_pos_o);
            wr_v_q.push_back(v_pos_o);
        end
    end

    function automatic logic [WORD_W-1:0] make_instr(input logic [OP_W-1:0] op,
                                                     input logic [ARG_W-1:0] arg);
        return {op, arg};
    endfunction

    function automatic logic [REG_ADDR_W-1:0] rand_reg();
        int unsigned r;
        r = $urandom;
        return r[REG_ADDR_W-1:0];
    endfunction

    function automatic logic [WORD_W-1:0] rand_data();
        int unsigned r;
        r = $urandom;
        return r[WORD_W-1:0];
    endfunction

    task automatic new_program();
        prog_words.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    // MOVE is the opcode word plus one data word
    // register number rides in the low argument bits
    task automatic add_move(input logic [REG_ADDR_W-1:0] ra, input logic [WORD_W-1:0] d,
                            input bit expected);
        prog_words.push_back(make_instr(OP_MOVE, ARG_W'(ra)));
        prog_words.push_back(d);
        if (expected) begin
            exp_addr.push_back(ra);
            exp_data.push_back(d);
        end
    endtask

    task automatic set_enable(input logic en);
        @(negedge clk);
        copper_en_i = en;
    endtask

    task automatic load_program();
        foreach (prog_words[i]) begin
            @(negedge clk);
            prog_wr_i   = 1'b1;
            prog_addr_i = AWIDTH'(i);
            prog_data_i = prog_words[i];
        end
        @(negedge clk);
        prog_wr_i = 1'b0;
    endtask

    task automatic write_word(input logic [AWIDTH-1:0] addr, input logic [WORD_W-1:0] d);
        @(negedge clk);
        prog_wr_i   = 1'b1;
        prog_addr_i = addr;
        prog_data_i = d;
        @(negedge clk);
        prog_wr_i = 1'b0;
    endtask

    task automatic wait_frame_start();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!frame_start_o && cycles < WAIT_LIMIT);
        if (!frame_start_o) begin
            $display("timeout: no frame start within %0d cycles", WAIT_LIMIT);
            errors++;
        end else begin
            // the pulse marks the top-left corner of the raster
            checks++;
            assert (h_pos_o == '0) else begin
                $display("Fail h_pos_o at frame start: got 0x%h expected 0x0", h_pos_o);
                errors++;
            end
            assert (v_pos_o == '0) else begin
                $display("Fail v_pos_o at frame start: got 0x%h expected 0x0", v_pos_o);
                errors++;
            end
        end
    endtask

    // log exactly one frame, from one frame start to the next
    task automatic record_frame();
        wait_frame_start();
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_h_q.delete();
        wr_v_q.delete();
        wait_frame_start();
    endtask

    task automatic check_writes(input string tag);
        int n;
        n = exp_addr.size();
        checks++;
        assert (wr_addr_q.size() == n) else begin
            $display("Fail reg_wr_o count in %s: got 0x%0h expected 0x%0h",
                     tag, wr_addr_q.size(), n);
            errors++;
        end
        for (int i = 0; i < n && i < wr_addr_q.size(); i++) begin
            checks++;
            assert (wr_addr_q[i] == exp_addr[i]) else begin
                $display("Fail reg_addr_o write %0d in %s: got 0x%h expected 0x%h",
                         i, tag, wr_addr_q[i], exp_addr[i]);
                errors++;
            end
            assert (wr_data_q[i] == exp_data[i]) else begin
                $display("Fail reg_data_o write %0d in %s: got 0x%h expected 0x%h",
                         i, tag, wr_data_q[i], exp_data[i]);
                errors++;
            end
        end
    endtask

    task automatic test_reset_idle();
        repeat (8) begin
            @(negedge clk);
            checks++;
            assert (reg_wr_o == 1'b0) else begin
                $display("Fail reg_wr_o after reset: got 0x%h expected 0x0", reg_wr_o);
                errors++;
            end
        end
        // memory still holds the fill word, the copper just waits
        new_program();
        set_enable(1'b1);
        record_frame();
        check_writes("unloaded memory");
        set_enable(1'b0);
        // loaded but disabled, two frames with no writes
        add_move(rand_reg(), rand_data(), 1'b0);
        prog_words.push_back(make_instr(OP_END, '0));
        load_program();
        record_frame();
        wait_frame_start();
        check_writes("disabled copper");
    endtask

    task automatic test_moves();
        new_program();
        repeat (5) add_move(rand_reg(), rand_data(), 1'b1);
        prog_words.push_back(make_instr(OP_END, '0));
        load_program();
        set_enable(1'b1);
        record_frame();
        check_writes("moves first frame");
        record_frame();
        check_writes("moves second frame");
        set_enable(1'b0);
    endtask

    task automatic test_waitv();
        int n;
        n = 2 + $urandom_range(7, 0);
        new_program();
        add_move(rand_reg(), rand_data(), 1'b1);
        prog_words.push_back(make_instr(OP_WAITV, ARG_W'(n)));
        add_move(rand_reg(), rand_data(), 1'b1);
        add_move(rand_reg(), rand_data(), 1'b1);
        prog_words.push_back(make_instr(OP_END, '0));
        load_program();
        set_enable(1'b1);
        record_frame();
        set_enable(1'b0);
        check_writes("waitv");
        foreach (wr_v_q[i]) begin
            checks++;
            if (i == 0) begin
                assert (wr_v_q[i] < n) else begin
                    $display("Fail v_pos_o write %0d: got 0x%h expected below 0x%h",
                             i, wr_v_q[i], n);
                    errors++;
                end
            end else begin
                assert (wr_v_q[i] >= n) else begin
                    $display("Fail v_pos_o write %0d: got 0x%h expected at least 0x%h",
                             i, wr_v_q[i], n);
                    errors++;
                end
            end
        end
    endtask

    task automatic test_waith();
        int n;
        int m;
        n = 2 + $urandom_range(7, 0);
        m = 8 + $urandom_range(22, 0);
        new_program();
        prog_words.push_back(make_instr(OP_WAITV, ARG_W'(n)));
        prog_words.push_back(make_instr(OP_WAITH, ARG_W'(m)));
        add_move(rand_reg(), rand_data(), 1'b1);
        prog_words.push_back(make_instr(OP_END, '0));
        load_program();
        set_enable(1'b1);
        record_frame();
        set_enable(1'b0);
        check_writes("waith");
        if (wr_v_q.size() > 0) begin
            checks++;
            assert (wr_v_q[0] == n) else begin
                $display("Fail v_pos_o after waith: got 0x%h expected 0x%h", wr_v_q[0], n);
                errors++;
            end
            assert (wr_h_q[0] >= m) else begin
                $display("Fail h_pos_o after waith: got 0x%h expected at least 0x%h",
                         wr_h_q[0], m);
                errors++;
            end
        end
    endtask

    task automatic test_jump_halt();
        // words 3 to 6 are jumped over
        new_program();
        add_move(rand_reg(), rand_data(), 1'b1);
        prog_words.push_back(make_instr(OP_JUMP, ARG_W'(7)));
        add_move(rand_reg(), rand_data(), 1'b0);
        add_move(rand_reg(), rand_data(), 1'b0);
        add_move(rand_reg(), rand_data(), 1'b1);
        prog_words.push_back(make_instr(OP_END, '0));
        load_program();
        set_enable(1'b1);
        record_frame();
        set_enable(1'b0);
        check_writes("jump");
        // opcode 0xf is undefined and stops the program
        new_program();
        add_move(rand_reg(), rand_data(), 1'b1);
        prog_words.push_back(make_instr(4'hf, '0));
        add_move(rand_reg(), rand_data(), 1'b0);
        prog_words.push_back(make_instr(OP_END, '0));
        load_program();
        set_enable(1'b1);
        record_frame();
        check_writes("halt first frame");
        record_frame();
        check_writes("halt second frame");
        set_enable(1'b0);
    endtask

    task automatic test_reprogram();
        int k;
        logic [WORD_W-1:0] d;
        new_program();
        repeat (3) add_move(rand_reg(), rand_data(), 1'b1);
        prog_words.push_back(make_instr(OP_END, '0));
        load_program();
        set_enable(1'b1);
        record_frame();
        check_writes("before reprogram");
        set_enable(1'b0);
        // data word of move k sits right after its opcode word
        k = $urandom_range(2, 0);
        d = ~exp_data[k];
        write_word(AWIDTH'(2 * k + 1), d);
        exp_data[k] = d;
        set_enable(1'b1);
        record_frame();
        check_writes("after reprogram");
        set_enable(1'b0);
    endtask

    initial begin
        int unsigned seed_val;
        checks      = 0;
        errors      = 0;
        rst_i       = 1'b1;
        copper_en_i = 1'b0;
        prog_wr_i   = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        seed_val    = $urandom(SEED);
        repeat (16) @(negedge clk);
        rst_i = 1'b0;

        test_reset_idle();
        test_moves();
        test_waitv();
        test_waith();
        test_jump_halt();
        test_reprogram();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
hdl/copper_pkg.sv
hdl/video_timing_pkg.sv
hdl/copper_mem.sv
hdl/beam_counter.sv
hdl/copper_fsm.sv
hdl/copper_top.sv
sim/copper_tb.sv
